// ==== src.f ====
+incdir+include
design/mem_pkg.sv
design/read_collector.sv
design/byte_counter.sv
design/bus_driver.sv
design/mem_arbiter_fsm.sv
design/mem_ctrl_top.sv
tests/mem_ctrl_props.sv
tests/mem_ctrl_tb.sv

// ==== tests/mem_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ctrl_tb import mem_pkg::*; ();

  localparam int num_random = 40;
  // directed requests plus up to two per random step
  localparam int num_reqs = 8 + 2 * num_random;

  logic        clk_in;
  logic        rst_in;
  logic        rdy_in;
  logic        is_io_buffer_full;
  logic        rdy_noise;
  byte_t       mem_din;
  byte_t       mem_dout;
  logic [31:0] mem_a;
  logic        mem_wr;
  fetch_req_t  fetch_req;
  data_req_t   data_req;
  io_req_t     io_req;
  line_rsp_t   fetch_rsp;
  line_rsp_t   data_rsp;
  byte_rsp_t   io_rsp;

  integer seed = 32'h3d80_6cf3;
  int     cyc = 0;
  byte_t  ram [0:(1 << `ADDR_W) - 1];
  // expected memory contents after completed data writes
  byte_t  ref_mem [0:(1 << `ADDR_W) - 1];
  logic   gap_pat [0:255];
  addr_t  io_log_addr [$];
  byte_t  io_log_data [$];
  time    data_ready_t;
  time    fetch_ready_t;

  mem_ctrl_top mem_ctrl_top_inst (.*);

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  initial begin
    #((num_reqs * `TB_CYCLES_PER_REQ + 20) * 40);
    stop_on_error("watchdog timeout, a request never completed");
  end

  // bound assertions count their failures
  always @(negedge clk_in) begin
    if (mem_ctrl_top_inst.props_inst.fail_count != 0) begin
      stop_on_error("a bound property check failed");
    end
  end

  // byte-wide RAM with uart writes going to the log
  always @(posedge clk_in) begin
    if (!rst_in && mem_a[31:`ADDR_W] !== '0) begin
      stop_on_error($sformatf("MISMATCH at %0t: mem_a[31:%0d] = %h, expected 0",
                              $time, `ADDR_W, mem_a[31:`ADDR_W]));
    end
    if (rdy_in && mem_wr) begin
      if (mem_a[`ADDR_W-1 -: 2] == 2'(`IO_SEL)) begin
        io_log_addr.push_back(mem_a[`ADDR_W-1:0]);
        io_log_data.push_back(mem_dout);
      end else begin
        ram[mem_a[`ADDR_W-1:0]] = mem_dout;
      end
    end
    #2;
    mem_din = ram[mem_a[`ADDR_W-1:0]];
  end

  always @(posedge clk_in) begin
    #2;
    rdy_in = rdy_noise ? gap_pat[cyc % 256] : 1'b1;
    cyc = cyc + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s = %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s = %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t: %s = %h, expected %h",
                              $time, name, got, exp));
    end
  endtask

  // byte k of the line comes from base+k
  function automatic line_t expect_line(input addr_t base);
    line_t exp;
    for (int k = 0; k < `LINE_BYTES; k++) begin
      exp[8*k +: 8] = ref_mem[base + addr_t'(k)];
    end
    return exp;
  endfunction

  function automatic line_t random_line();
    line_t line;
    for (int k = 0; k < `LINE_BYTES; k++) begin
      line[8*k +: 8] = byte_t'($random(seed));
    end
    return line;
  endfunction

  // line base below the I/O window that never runs into it
  function automatic addr_t mem_addr();
    logic [1:0]  sel;
    logic [15:0] low;
    sel = 2'($unsigned($random(seed)) % 3);
    low = 16'($random(seed));
    if (low > 16'(16'hffff - (`LINE_BYTES - 1))) begin
      low = 16'(16'hffff - (`LINE_BYTES - 1));
    end
    return {sel, low};
  endfunction

  function automatic addr_t io_addr();
    return {2'(`IO_SEL), 16'($random(seed))};
  endfunction

  task automatic fetch_read(input addr_t base);
    fetch_req = '{valid: 1'b1, addr: base};
    do @(negedge clk_in); while (!fetch_rsp.ready);
    fetch_ready_t = $time;
    check_line("fetch_rsp.line", fetch_rsp.line, expect_line(base));
    @(posedge clk_in);
    #2;
    fetch_req.valid = 1'b0;
  endtask

  task automatic data_read(input addr_t base);
    data_req = '{valid: 1'b1, write: 1'b0, addr: base, line: '0};
    do @(negedge clk_in); while (!data_rsp.ready);
    data_ready_t = $time;
    check_line("data_rsp.line", data_rsp.line, expect_line(base));
    @(posedge clk_in);
    #2;
    data_req.valid = 1'b0;
  endtask

  task automatic data_write(input addr_t base, input line_t line);
    data_req = '{valid: 1'b1, write: 1'b1, addr: base, line: line};
    do @(negedge clk_in); while (!data_rsp.ready);
    for (int k = 0; k < `LINE_BYTES; k++) begin
      ref_mem[base + addr_t'(k)] = line[8*k +: 8];
    end
    @(posedge clk_in);
    #2;
    data_req.valid = 1'b0;
  endtask

  task automatic data_beats_fetch(input addr_t d_base, input addr_t f_base);
    fork
      data_read(d_base);
      fetch_read(f_base);
    join
    if (fetch_ready_t <= data_ready_t) begin
      stop_on_error("fetch was answered before the data port");
    end
  endtask

  task automatic io_read(input addr_t addr);
    io_req = '{valid: 1'b1, write: 1'b0, addr: addr, data: 8'h00};
    do @(negedge clk_in); while (!io_rsp.ready);
    check_byte("io_rsp.data", io_rsp.data, ref_mem[addr]);
    @(posedge clk_in);
    #2;
    io_req.valid = 1'b0;
  endtask

  // stall counts the cycles the uart buffer stays full
  task automatic io_write(input addr_t addr, input byte_t val, input int stall);
    int n_log;
    n_log = io_log_addr.size();
    is_io_buffer_full = (stall > 0);
    io_req = '{valid: 1'b1, write: 1'b1, addr: addr, data: val};
    repeat (stall) begin
      @(negedge clk_in);
      if (mem_wr || io_rsp.ready) begin
        stop_on_error("I/O write went out while the UART buffer was full");
      end
    end
    if (stall > 0) begin
      @(posedge clk_in);
      #2;
      is_io_buffer_full = 1'b0;
    end
    do @(negedge clk_in); while (!io_rsp.ready);
    @(posedge clk_in);
    #2;
    io_req.valid = 1'b0;
    if (io_log_addr.size() != n_log + 1) begin
      stop_on_error("I/O write did not reach the I/O log exactly once");
    end
    check_addr("io log address", io_log_addr[n_log], addr);
    check_byte("io log byte", io_log_data[n_log], val);
  endtask

  initial begin
    addr_t base;
    addr_t addr;
    byte_t val;
    int    stall;
    int    kind;
    rst_in = 1'b1;
    rdy_in = 1'b1;
    rdy_noise = 1'b0;
    is_io_buffer_full = 1'b0;
    mem_din = '0;
    fetch_req = '0;
    data_req = '0;
    io_req = '0;
    for (int i = 0; i < (1 << `ADDR_W); i++) begin
      ram[i] = byte_t'($random(seed));
      ref_mem[i] = ram[i];
    end
    for (int i = 0; i < 256; i++) begin
      gap_pat[i] = (($random(seed) & 3) != 0);
    end
    repeat (4) @(posedge clk_in);
    #2;
    rst_in = 1'b0;

    fetch_read(mem_addr());
    base = mem_addr();
    data_write(base, random_line());
    data_read(base);
    data_beats_fetch(base, mem_addr());
    io_read(io_addr());
    addr = io_addr();
    val = byte_t'($random(seed));
    io_write(addr, val, 0);
    addr = io_addr();
    val = byte_t'($random(seed));
    io_write(addr, val, 5);

    // mixed traffic with rdy_in gaps
    @(negedge clk_in);
    rdy_noise = 1'b1;
    @(posedge clk_in);
    #2;
    repeat (num_random) begin
      kind = $random(seed) & 7;
      case (kind)
        0, 1: fetch_read(mem_addr());
        2: begin
          base = mem_addr();
          data_write(base, random_line());
        end
        3: data_read(base);
        4: data_read(mem_addr());
        5: io_read(io_addr());
        6: begin
          addr = io_addr();
          val = byte_t'($random(seed));
          stall = $random(seed) & 7;
          io_write(addr, val, stall);
        end
        default: data_beats_fetch(base, mem_addr());
      endcase
    end
    @(negedge clk_in);
    rdy_noise = 1'b0;
    repeat (2) @(posedge clk_in);
    #2;

    for (int i = 0; i < (1 << `ADDR_W); i++) begin
      if (ram[i] !== ref_mem[i]) begin
        check_byte($sformatf("ram[%h]", i), ram[i], ref_mem[i]);
      end
    end
    if (mem_ctrl_top_inst.props_inst.fail_count != 0) begin
      stop_on_error("a bound property check failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// ==== tests/mem_ctrl_props.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ctrl_props import mem_pkg::*; (
  input logic        clk_in,
  input logic        rst_in,
  input logic        rdy_in,
  input logic        is_io_buffer_full,
  input logic [31:0] mem_a,
  input logic        mem_wr,
  input line_rsp_t   fetch_rsp,
  input line_rsp_t   data_rsp,
  input byte_rsp_t   io_rsp
);

  int fail_count = 0;
  logic [2:0] readies;

  assign readies = {fetch_rsp.ready, data_rsp.ready, io_rsp.ready};

  // a response strobe is a single-cycle pulse
  ready_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    (|readies) |=> !(|readies))
    else begin
      fail_count++;
      $error("ready strobe lasted more than one cycle");
    end

  one_ready: assert property (@(posedge clk_in) disable iff (rst_in)
    $onehot0(readies))
    else begin
      fail_count++;
      $error("more than one ready strobe high in the same cycle");
    end

  // uart writes only while its buffer has room
  io_write_room: assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_wr && mem_a[`ADDR_W-1 -: 2] == 2'(`IO_SEL)) |-> !is_io_buffer_full)
    else begin
      fail_count++;
      $error("I/O write on the bus while the UART buffer was full");
    end

  addr_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    !rdy_in |=> $stable(mem_a))
    else begin
      fail_count++;
      $error("mem_a changed while rdy_in was low");
    end

endmodule

bind mem_ctrl_top mem_ctrl_props props_inst (.*);

// ==== design/mem_ctrl_top.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ctrl_top import mem_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       rdy_in,
  input  byte_t      mem_din,
  output byte_t      mem_dout,
  output logic [31:0] mem_a,
  output logic       mem_wr,
  input  logic       is_io_buffer_full,
  input  fetch_req_t fetch_req,
  input  data_req_t  data_req,
  input  io_req_t    io_req,
  output line_rsp_t  fetch_rsp,
  output line_rsp_t  data_rsp,
  output byte_rsp_t  io_rsp
);

  src_t  grant;
  logic  busy_write;
  logic  xfer_en;
  logic  count_clr;
  logic  single;
  logic  last;
  logic  fetch_ready;
  logic  data_ready;
  logic  io_ready;
  logic  read_issued;
  logic [$clog2(`LINE_BYTES)-1:0] count;
  addr_t ram_addr;
  line_t line_payload;
  byte_t byte_payload;

  mem_arbiter_fsm arbiter_inst (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .rdy_in            (rdy_in),
    .fetch_req         (fetch_req),
    .data_req          (data_req),
    .io_req            (io_req),
    .is_io_buffer_full (is_io_buffer_full),
    .last              (last),
    .grant             (grant),
    .busy_write        (busy_write),
    .xfer_en           (xfer_en),
    .count_clr         (count_clr),
    .single            (single),
    .fetch_ready       (fetch_ready),
    .data_ready        (data_ready),
    .io_ready          (io_ready)
  );

  byte_counter counter_inst (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .count_clr (count_clr),
    .xfer_en   (xfer_en),
    .single    (single),
    .count     (count),
    .last      (last)
  );

  bus_driver driver_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .grant       (grant),
    .busy_write  (busy_write),
    .xfer_en     (xfer_en),
    .count       (count),
    .fetch_req   (fetch_req),
    .data_req    (data_req),
    .io_req      (io_req),
    .ram_addr    (ram_addr),
    .ram_dout    (mem_dout),
    .ram_wr      (mem_wr),
    .read_issued (read_issued)
  );

  // fetch and data reads share one line buffer, only one is granted at a time
  read_collector #(.payload_t(line_t)) line_col (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .read_issued (read_issued),
    .ram_din     (mem_din),
    .payload     (line_payload)
  );

  read_collector #(.payload_t(byte_t)) byte_col (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .read_issued (read_issued),
    .ram_din     (mem_din),
    .payload     (byte_payload)
  );

  assign mem_a = {{(32-`ADDR_W){1'b0}}, ram_addr};

  assign fetch_rsp = '{ready: fetch_ready, line: line_payload};
  assign data_rsp  = '{ready: data_ready, line: line_payload};
  assign io_rsp    = '{ready: io_ready, data: byte_payload};

endmodule

// ==== design/mem_arbiter_fsm.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_arbiter_fsm import mem_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       rdy_in,
  input  fetch_req_t fetch_req,
  input  data_req_t  data_req,
  input  io_req_t    io_req,
  input  logic       is_io_buffer_full,
  input  logic       last,
  output src_t       grant,
  output logic       busy_write,
  output logic       xfer_en,
  output logic       count_clr,
  output logic       single,
  output logic       fetch_ready,
  output logic       data_ready,
  output logic       io_ready
);

  typedef enum logic [2:0] {
    idle,
    io_wait,
    xfer,
    drain,
    done
  } state_t;

  state_t state;
  state_t state_nxt;
  src_t   pick;
  logic   io_stall;

  // fixed priority, data before io before fetch
  always_comb begin
    pick = src_none;
    if (data_req.valid) begin
      pick = src_data;
    end else if (io_req.valid) begin
      pick = src_io;
    end else if (fetch_req.valid) begin
      pick = src_fetch;
    end
  end

  // uart write while its tx buffer is full
  assign io_stall = io_req.write && is_io_buffer_full &&
                    (io_req.addr[`ADDR_W-1 -: 2] == 2'(`IO_SEL));

  assign count_clr = (state == idle) && (pick != src_none);
  assign xfer_en   = (state == xfer);

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (count_clr) begin
          state_nxt = (pick == src_io && io_stall) ? io_wait : xfer;
        end
      end
      io_wait: begin
        if (!io_stall) begin
          state_nxt = xfer;
        end
      end
      xfer: begin
        // writes need no turnaround, reads wait for the final byte
        if (last) begin
          state_nxt = busy_write ? done : drain;
        end
      end
      drain: state_nxt = done;
      done: state_nxt = idle;
      default: state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= idle;
      grant      <= src_none;
      busy_write <= 1'b0;
      single     <= 1'b0;
    end else if (rdy_in) begin
      state <= state_nxt;
      if (count_clr) begin
        grant      <= pick;
        busy_write <= (pick == src_data && data_req.write) ||
                      (pick == src_io && io_req.write);
        single     <= (pick == src_io);
      end else if (state == done) begin
        grant <= src_none;
      end
    end
  end

  // only the active done cycle, so a pause cannot stretch the pulse
  assign fetch_ready = rdy_in && (state == done) && (grant == src_fetch);
  assign data_ready  = rdy_in && (state == done) && (grant == src_data);
  assign io_ready    = rdy_in && (state == done) && (grant == src_io);

endmodule

// ==== design/bus_driver.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module bus_driver import mem_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic       rdy_in,
  input  src_t       grant,
  input  logic       busy_write,
  input  logic       xfer_en,
  input  logic [$clog2(`LINE_BYTES)-1:0] count,
  input  fetch_req_t fetch_req,
  input  data_req_t  data_req,
  input  io_req_t    io_req,
  output addr_t      ram_addr,
  output byte_t      ram_dout,
  output logic       ram_wr,
  output logic       read_issued
);

  addr_t base_addr;
  byte_t wr_byte;

  // requesters hold their fields until ready, so no copy is kept here
  always_comb begin
    base_addr = '0;
    wr_byte   = '0;
    case (grant)
      src_data: begin
        base_addr = data_req.addr;
        wr_byte   = data_req.line[8*count +: 8];
      end
      src_io: begin
        base_addr = io_req.addr;
        wr_byte   = io_req.data;
      end
      src_fetch: base_addr = fetch_req.addr;
      default: base_addr = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ram_addr    <= '0;
      ram_dout    <= '0;
      ram_wr      <= 1'b0;
      read_issued <= 1'b0;
    end else if (rdy_in) begin
      if (xfer_en) begin
        ram_addr    <= base_addr + addr_t'(count);
        ram_dout    <= wr_byte;
        ram_wr      <= busy_write;
        read_issued <= !busy_write;
      end else begin
        // bus idles at address 0 with no write
        ram_addr    <= '0;
        ram_dout    <= '0;
        ram_wr      <= 1'b0;
        read_issued <= 1'b0;
      end
    end
  end

endmodule

// ==== design/byte_counter.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module byte_counter (
  input  logic clk_in,
  input  logic rst_in,
  input  logic rdy_in,
  input  logic count_clr,
  input  logic xfer_en,
  input  logic single,
  output logic [$clog2(`LINE_BYTES)-1:0] count,
  output logic last
);

  localparam int cnt_w = $clog2(`LINE_BYTES);
  localparam logic [cnt_w-1:0] last_idx = cnt_w'(`LINE_BYTES - 1);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count <= '0;
    end else if (rdy_in) begin
      if (count_clr) begin
        count <= '0;
      end else if (xfer_en) begin
        count <= count + 1'b1;
      end
    end
  end

  // io transfers are one byte long
  assign last = single ? (count == '0) : (count == last_idx);

endmodule

// ==== design/read_collector.sv ====
`timescale 1ns/1ps

module read_collector import mem_pkg::*; #(
  parameter type payload_t = byte_t
) (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     rdy_in,
  input  logic     read_issued,
  input  byte_t    ram_din,
  output payload_t payload
);

  localparam int payload_w = $bits(payload_t);

  logic [payload_w+7:0] shifted;

  // new byte enters at the top, the oldest one ends up at bits 7:0
  assign shifted = {ram_din, payload} >> 8;

  // byte for the address issued at one edge is taken at the next
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      payload <= '0;
    end else if (rdy_in && read_issued) begin
      payload <= shifted[payload_w-1:0];
    end
  end

endmodule

// ==== design/mem_pkg.sv ====
`include "mem_consts.svh"

package mem_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [7:0] byte_t;

  // byte k of a line belongs to address base+k
  typedef logic [`LINE_BYTES*8-1:0] line_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    line_t line;
  } data_req_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    byte_t data;
  } io_req_t;

  typedef struct packed {
    logic  ready;
    line_t line;
  } line_rsp_t;

  typedef struct packed {
    logic  ready;
    byte_t data;
  } byte_rsp_t;

  typedef enum logic [1:0] {
    src_none,
    src_data,
    src_io,
    src_fetch
  } src_t;

endpackage

// ==== include/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bytes per cache line
`define LINE_BYTES 4

// RAM address bits that are actually decoded
`define ADDR_W 18

// value of addr[17:16] that maps to the uart
`define IO_SEL 3

// watchdog budget per request, generous for rdy_in gaps and waiting
`define TB_CYCLES_PER_REQ 64

`endif
